// ==== ipic_top.f ====
design/ipic_pkg.sv
design/ipic_irq_frontend.sv
design/ipic_cfg_regs.sv
design/ipic_pending.sv
design/ipic_prio_enc.sv
design/ipic_service.sv
design/ipic_reg_ctrl.sv
design/ipic_top.sv
dv/ipic_tb_clk.sv
dv/ipic_tb.sv

// ==== dv/ipic_tb.sv ====
`timescale 1ns/1ps

module ipic_tb;
    import ipic_pkg::*;

    localparam int TIMEOUT = 10;                  // Cycles per wait loop

    logic     clk;
    logic     rst_n;
    irq_vec_t irq_lines;
    csr_req_t csr_req;
    xlen_t    rdata;
    logic     irq_req;

    integer seed     = 32'h0e7f_fcdb;
    int     errors   = 0;
    int     timeouts = 0;
    int     settle   = 0;                         // Cycles left before req compare resumes
    bit     run      = 1'b0;

    // Reference state
    irq_vec_t  m_lines, m_inv, m_imr, m_ier;
    irq_vec_t  m_edge;                            // Latched edge-mode pending
    irq_vec_t  m_isvr;
    irq_idx_t  m_idx;
    irq_vec_t  cmp_pend;
    vect_num_t cmp_cisv;
    logic      cmp_req;

    ipic_tb_clk u_clk (.clk_o (clk), .rst_n_o (rst_n));

    ipic_top #(.SYNC_EN (1'b1)) u_ipic_top (
        .clk, .rst_n, .irq_lines_i (irq_lines), .csr_req_i (csr_req),
        .rdata_o (rdata), .irq_req_o (irq_req)
    );

    //----------------------------------------
    // Reference model
    //----------------------------------------
    function automatic vect_num_t lowest_set(irq_vec_t v);
        vect_num_t r;
        r = VOID_VECT;
        for (int i = IRQ_NUM-1; i >= 0; i--) begin
            if (v[i]) r = vect_num_t'(i);   // Lowest index wins
        end
        return r;
    endfunction

    function automatic void ref_model(output irq_vec_t pend, output vect_num_t cisv,
                                      output logic req);
        vect_num_t best;
        pend = (~m_imr & (m_lines ^ m_inv)) | (m_imr & m_edge);   // Level follows line
        cisv = lowest_set(m_isvr);               // Nested starts are always lower
        best = lowest_set(pend & m_ier);
        req  = (best != VOID_VECT) && (best < cisv);
    endfunction

    // ICSR word of the indexed line
    function automatic xlen_t icsr_expect(irq_vec_t pend);
        xlen_t w;
        w                           = '0;
        w[ICSR_IP]                  = pend[m_idx];
        w[ICSR_IE]                  = m_ier[m_idx];
        w[ICSR_IM]                  = m_imr[m_idx];
        w[ICSR_INV]                 = m_inv[m_idx];
        w[ICSR_IS]                  = m_isvr[m_idx];
        w[ICSR_LN_LSB +: IRQ_IDX_W] = m_idx;
        return w;
    endfunction

    //----------------------------------------
    // Compare tasks
    //----------------------------------------
    task automatic check_vec(irq_vec_t got, irq_vec_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s reads %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vnum(vect_num_t got, vect_num_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s reads %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(xlen_t got, xlen_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s reads %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Request compared every cycle except while line events settle
    always @(negedge clk) begin
        if (run) begin
            if (settle > 0) begin
                settle--;
            end else begin
                ref_model(cmp_pend, cmp_cisv, cmp_req);
                check_bit(irq_req, cmp_req, "irq_req_o");
            end
        end
    end

    //----------------------------------------
    // Bus and line drivers
    //----------------------------------------
    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_reg(reg_addr_t addr, output xlen_t data);
        csr_req.rd   = 1'b1;
        csr_req.addr = addr;
        #2 data = rdata;                          // Combinational read data
        @(posedge clk);
        #1;
        csr_req = '0;
    endtask

    task automatic write_reg(reg_addr_t addr, xlen_t data);
        irq_vec_t  p;
        vect_num_t c;
        logic      r;
        vect_num_t b;
        ref_model(p, c, r);                       // State seen by the write
        csr_req.wr    = 1'b1;
        csr_req.addr  = addr;
        csr_req.wdata = data;
        @(posedge clk);
        #1;
        csr_req = '0;
        case (addr)
            ADDR_IPR:  m_edge &= ~data[IRQ_NUM-1:0];
            ADDR_IDX:  m_idx = data[IRQ_IDX_W-1:0];
            ADDR_ICSR: begin
                // Level to edge keeps the level seen with the new inversion
                if (!m_imr[m_idx] && data[ICSR_IM]) m_edge[m_idx] = m_lines[m_idx] ^ data[ICSR_INV];
                else if (data[ICSR_IP])             m_edge[m_idx] = 1'b0;
                m_ier[m_idx] = data[ICSR_IE];
                m_imr[m_idx] = data[ICSR_IM];
                m_inv[m_idx] = data[ICSR_INV];
                settle = 2;                       // Mode switch lags a cycle
            end
            ADDR_SOI: if (r) begin
                b = lowest_set(p & m_ier);
                m_isvr[b[IRQ_IDX_W-1:0]] = 1'b1;
                m_edge[b[IRQ_IDX_W-1:0]] = 1'b0;
            end
            ADDR_EOI: if (m_isvr != '0) begin
                b = lowest_set(m_isvr);
                m_isvr[b[IRQ_IDX_W-1:0]] = 1'b0;
            end
            default: ;
        endcase
    endtask

    task automatic drive_lines(irq_vec_t v);
        m_edge   |= m_imr & (v ^ m_lines) & (v ^ m_inv);   // Toggle into active
        m_lines   = v;
        irq_lines = v;
        settle    = 4;                            // Sync plus pending register
    endtask

    task automatic wait_pending(irq_vec_t mask, irq_vec_t want);
        xlen_t d;
        int    n;
        bit    hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < TIMEOUT) begin
            read_reg(ADDR_IPR, d);
            hit = ((d[IRQ_NUM-1:0] & mask) == want);
            n++;
        end
        if (!hit) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting on pending bits %h", TIMEOUT, mask);
        end
    endtask

    task automatic check_state(string what);
        irq_vec_t  p;
        vect_num_t c;
        logic      r;
        xlen_t     d;
        ref_model(p, c, r);
        check_bit(irq_req, r, {what, ": irq_req_o"});
        read_reg(ADDR_IPR, d);
        check_vec(d[IRQ_NUM-1:0], p, {what, ": IPR"});
        read_reg(ADDR_ISVR, d);
        check_vec(d[IRQ_NUM-1:0], m_isvr, {what, ": ISVR"});
        read_reg(ADDR_CISV, d);
        check_vnum(d[IRQ_IDX_W:0], c, {what, ": CISV"});
        read_reg(ADDR_ICSR, d);
        check_word(d, icsr_expect(p), {what, ": ICSR"});
    endtask

    //----------------------------------------
    // Stimulus
    //----------------------------------------
    initial begin
        xlen_t    d;
        xlen_t    cfg;
        irq_idx_t l1, l2, n_line;
        irq_vec_t s_mask;
        irq_lines = '0;
        csr_req   = '0;
        m_lines   = '0;
        m_inv     = '0;
        m_imr     = '0;
        m_ier     = '0;
        m_edge    = '0;
        m_isvr    = '0;
        m_idx     = '0;
        for (int i = 0; i < 20 && rst_n !== 1'b1; i++) @(posedge clk);
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Reset was never released");
        end
        #1;
        run = 1'b1;

        // Reset values
        check_state("reset");

        // Level mode on one line
        l1 = irq_idx_t'($random(seed));
        write_reg(ADDR_IDX, xlen_t'(l1));
        write_reg(ADDR_ICSR, xlen_t'(1) << ICSR_IE);
        drive_lines(irq_vec_t'(1) << l1);
        wait_pending(irq_vec_t'(1) << l1, irq_vec_t'(1) << l1);
        check_state("level raise");
        drive_lines('0);
        wait_pending(irq_vec_t'(1) << l1, '0);
        check_state("level drop");

        // Inverted edge mode on a line idling high
        l2 = l1 + irq_idx_t'(1 + ($random(seed) & 7));
        drive_lines(irq_vec_t'(1) << l2);
        wait_pending(irq_vec_t'(1) << l2, irq_vec_t'(1) << l2);
        write_reg(ADDR_IDX, xlen_t'(l2));
        write_reg(ADDR_ICSR, (xlen_t'(1) << ICSR_IE) | (xlen_t'(1) << ICSR_IM)
                             | (xlen_t'(1) << ICSR_INV));
        drive_lines('0);                          // Falling edge
        wait_pending(irq_vec_t'(1) << l2, irq_vec_t'(1) << l2);
        check_state("edge set");
        drive_lines(irq_vec_t'(1) << l2);
        idle(6);
        check_state("edge hold");
        write_reg(ADDR_IPR, xlen_t'(1) << l2);    // Write 1 clears
        check_state("IPR clear");
        write_reg(ADDR_ICSR, '0);
        drive_lines('0);
        wait_pending(irq_vec_t'(1) << l2, '0);

        // Priority and nesting
        s_mask = (irq_vec_t'($random(seed)) & 16'hfff0) | 16'h0100;
        n_line = irq_idx_t'($random(seed) & 3);   // Below every line in s_mask
        for (int i = 0; i < IRQ_NUM; i++) begin
            if (s_mask[i] || irq_idx_t'(i) == n_line) begin
                write_reg(ADDR_IDX, xlen_t'(i));
                write_reg(ADDR_ICSR, (xlen_t'(1) << ICSR_IE) | (xlen_t'(1) << ICSR_IM)
                                     | (xlen_t'(1) << ICSR_IP));
            end
        end
        drive_lines(s_mask);
        wait_pending(s_mask, s_mask);
        check_state("several pending");
        write_reg(ADDR_SOI, '0);
        check_state("first SOI");
        drive_lines(s_mask | (irq_vec_t'(1) << n_line));
        wait_pending(irq_vec_t'(1) << n_line, irq_vec_t'(1) << n_line);
        check_state("nested request");
        write_reg(ADDR_SOI, '0);
        write_reg(ADDR_IDX, xlen_t'(n_line));    // ICSR shows the nested line
        check_state("nested SOI");
        write_reg(ADDR_EOI, '0);
        check_state("first EOI");
        write_reg(ADDR_EOI, '0);
        check_state("second EOI");

        // ICSR readback over all lines
        for (int i = 0; i < IRQ_NUM; i++) begin
            d             = xlen_t'($random(seed));
            cfg           = '0;
            cfg[ICSR_IE]  = d[0];
            cfg[ICSR_IM]  = d[1];
            cfg[ICSR_INV] = d[2];
            write_reg(ADDR_IDX, xlen_t'(i));
            write_reg(ADDR_ICSR, cfg);
            read_reg(ADDR_ICSR, d);
            // Pending bit lags a mode switch by a cycle
            check_word(d & ~(xlen_t'(1) << ICSR_IP), icsr_expect('0), "ICSR readback");
        end
        for (int i = 0; i < IRQ_NUM; i++) begin
            write_reg(ADDR_IDX, xlen_t'(i));
            write_reg(ADDR_ICSR, '0);             // Everything off
        end
        idle(3);
        check_state("all disabled");
        write_reg(ADDR_SOI, '0);                  // No request so nothing starts
        check_state("SOI without request");

        idle(2);
        run = 1'b0;
        $display("Run complete with %0d value errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/ipic_tb_clk.sv ====
`timescale 1ns/1ps

module ipic_tb_clk (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int HALF_NS    = 4;   // 8 ns period
    localparam int RST_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_NS clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;               // Release away from the edge
    end

endmodule

// ==== design/ipic_top.sv ====
`timescale 1ns/1ps

module ipic_top #(
    parameter bit SYNC_EN = 1'b1                  // Synchronize external lines
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ipic_pkg::irq_vec_t irq_lines_i,       // From the SoC
    input  ipic_pkg::csr_req_t csr_req_i,         // From the core
    output ipic_pkg::xlen_t    rdata_o,
    output logic               irq_req_o
);
    import ipic_pkg::*;

    //----------------------------------------
    // Interconnect
    //----------------------------------------
    cfg_cmd_t  cfg_cmd;
    irq_vec_t  clr_req;
    logic      soi_wr, eoi_wr;
    irq_vec_t  ier, imr, iinv, iinv_next;
    irq_idx_t  idx;
    irq_vec_t  lvl, edge_det;
    irq_vec_t  ipr, isvr, isvr_eoi;
    vect_num_t cisv;
    prio_t     req_prio;                          // Best pending and enabled
    prio_t     eoi_prio;                          // Best left after EOI
    logic      start_en;

    ipic_reg_ctrl u_reg_ctrl (
        .clk, .rst_n, .csr_req_i,
        .ipr_i (ipr), .isvr_i (isvr), .ier_i (ier), .imr_i (imr), .iinv_i (iinv),
        .idx_i (idx), .cisv_i (cisv),
        .cfg_cmd_o (cfg_cmd), .clr_req_o (clr_req),
        .soi_wr_o (soi_wr), .eoi_wr_o (eoi_wr), .rdata_o
    );

    ipic_irq_frontend #(.SYNC_EN (SYNC_EN)) u_frontend (
        .clk, .rst_n, .lines_i (irq_lines_i), .inv_i (iinv_next),
        .lvl_o (lvl), .edge_o (edge_det)
    );

    ipic_cfg_regs u_cfg_regs (
        .clk, .rst_n, .cmd_i (cfg_cmd),
        .ier_o (ier), .imr_o (imr), .iinv_o (iinv), .iinv_next_o (iinv_next), .idx_o (idx)
    );

    ipic_pending u_pending (
        .clk, .rst_n, .lvl_i (lvl), .edge_i (edge_det), .imr_i (imr), .clr_req_i (clr_req),
        .start_i (req_prio), .start_en_i (start_en), .ipr_o (ipr)
    );

    ipic_prio_enc u_prio_req (.vec_i (ipr & ier), .res_o (req_prio));
    ipic_prio_enc u_prio_eoi (.vec_i (isvr_eoi),  .res_o (eoi_prio));

    ipic_service u_service (
        .clk, .rst_n, .req_i (req_prio), .eoi_next_i (eoi_prio),
        .soi_wr_i (soi_wr), .eoi_wr_i (eoi_wr), .start_en_o (start_en),
        .isvr_o (isvr), .isvr_eoi_o (isvr_eoi), .cisv_o (cisv), .irq_req_o
    );

endmodule

// ==== design/ipic_reg_ctrl.sv ====
`timescale 1ns/1ps

module ipic_reg_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::csr_req_t  csr_req_i,        // Register request from core
    input  ipic_pkg::irq_vec_t  ipr_i,
    input  ipic_pkg::irq_vec_t  isvr_i,
    input  ipic_pkg::irq_vec_t  ier_i,
    input  ipic_pkg::irq_vec_t  imr_i,
    input  ipic_pkg::irq_vec_t  iinv_i,
    input  ipic_pkg::irq_idx_t  idx_i,
    input  ipic_pkg::vect_num_t cisv_i,
    output ipic_pkg::cfg_cmd_t  cfg_cmd_o,        // IDX/ICSR write command
    output ipic_pkg::irq_vec_t  clr_req_o,        // Pending clear mask
    output logic                soi_wr_o,
    output logic                eoi_wr_o,
    output ipic_pkg::xlen_t     rdata_o
);
    import ipic_pkg::*;

    logic  wr_ipr;
    logic  wr_idx;
    logic  wr_icsr;
    xlen_t icsr_word;                             // ICSR view of indexed line

    //----------------------------------------
    // Write decode
    //----------------------------------------
    assign wr_ipr   = csr_req_i.wr && (csr_req_i.addr == ADDR_IPR);
    assign wr_idx   = csr_req_i.wr && (csr_req_i.addr == ADDR_IDX);
    assign wr_icsr  = csr_req_i.wr && (csr_req_i.addr == ADDR_ICSR);
    assign soi_wr_o = csr_req_i.wr && (csr_req_i.addr == ADDR_SOI);   // Data ignored
    assign eoi_wr_o = csr_req_i.wr && (csr_req_i.addr == ADDR_EOI);   // Data ignored

    assign cfg_cmd_o.idx_wr  = wr_idx;
    assign cfg_cmd_o.icsr_wr = wr_icsr;
    assign cfg_cmd_o.wdata   = csr_req_i.wdata;

    // Write 1 to clear pending
    always_comb begin
        clr_req_o = '0;
        if (wr_ipr) begin
            clr_req_o = csr_req_i.wdata[IRQ_NUM-1:0];
        end else if (wr_icsr) begin
            clr_req_o[idx_i] = csr_req_i.wdata[ICSR_IP];   // Only the indexed line
        end
    end

    //----------------------------------------
    // Read data
    //----------------------------------------
    always_comb begin
        icsr_word                             = '0;
        icsr_word[ICSR_IP]                    = ipr_i[idx_i];
        icsr_word[ICSR_IE]                    = ier_i[idx_i];
        icsr_word[ICSR_IM]                    = imr_i[idx_i];
        icsr_word[ICSR_INV]                   = iinv_i[idx_i];
        icsr_word[ICSR_IS]                    = isvr_i[idx_i];
        icsr_word[ICSR_LN_LSB +: IRQ_IDX_W]   = idx_i;   // Line number echo
    end

    always_comb begin
        rdata_o = '0;                             // Idle bus reads zero
        if (csr_req_i.rd) begin
            case (csr_req_i.addr)
                ADDR_CISV: rdata_o = xlen_t'(cisv_i);
                ADDR_IPR:  rdata_o = xlen_t'(ipr_i);
                ADDR_ISVR: rdata_o = xlen_t'(isvr_i);
                ADDR_IDX:  rdata_o = xlen_t'(idx_i);
                ADDR_ICSR: rdata_o = icsr_word;
                default:   rdata_o = '0;          // EOI, SOI, unused hole
            endcase
        end
    end

    // One request type per cycle from the core
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(csr_req_i.rd && csr_req_i.wr))
        else $error("Read and write strobes high together");

endmodule

// ==== design/ipic_service.sv ====
`timescale 1ns/1ps

module ipic_service (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::prio_t     req_i,            // Best pending and enabled line
    input  ipic_pkg::prio_t     eoi_next_i,       // Best remaining in service
    input  logic                soi_wr_i,
    input  logic                eoi_wr_i,
    output logic                start_en_o,       // Interrupt starts this cycle
    output ipic_pkg::irq_vec_t  isvr_o,
    output ipic_pkg::irq_vec_t  isvr_eoi_o,       // ISVR minus current line
    output ipic_pkg::vect_num_t cisv_o,
    output logic                irq_req_o         // Request to the core
);
    import ipic_pkg::*;

    vect_num_t cisv_q, cisv_next;
    irq_vec_t  isvr_q, isvr_next;
    logic      serv_vd;                           // Something in service
    irq_idx_t  serv_idx;
    logic      eoi_en;

    assign serv_vd  = ~cisv_q[IRQ_IDX_W];          // VOID_VECT has MSB set
    assign serv_idx = cisv_q[IRQ_IDX_W-1:0];

    // Higher priority means lower index
    assign irq_req_o  = req_i.vd & (~serv_vd | (req_i.idx < serv_idx));
    assign start_en_o = soi_wr_i & irq_req_o;
    assign eoi_en     = eoi_wr_i & serv_vd;        // EOI when idle is dropped

    always_comb begin
        isvr_eoi_o = isvr_q;
        if (serv_vd) isvr_eoi_o[serv_idx] = 1'b0;
    end

    //----------------------------------------
    // Start / end of interrupt
    //----------------------------------------
    always_comb begin
        isvr_next = isvr_q;
        cisv_next = cisv_q;
        if (start_en_o) begin
            isvr_next[req_i.idx] = 1'b1;
            cisv_next            = {1'b0, req_i.idx};
        end else if (eoi_en) begin
            isvr_next = isvr_eoi_o;
            cisv_next = eoi_next_i.vd ? {1'b0, eoi_next_i.idx} : VOID_VECT;   // Back to outer level
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= VOID_VECT;
        end else begin
            isvr_q <= isvr_next;
            cisv_q <= cisv_next;
        end
    end

    assign isvr_o = isvr_q;
    assign cisv_o = cisv_q;

    // Current vector and in-service set must agree on idleness
    a_cisv_void: assert property (@(posedge clk) disable iff (!rst_n)
        (cisv_q == VOID_VECT) == (isvr_q == '0))
        else $error("CISV and ISVR disagree on idle state");

endmodule

// ==== design/ipic_prio_enc.sv ====
`timescale 1ns/1ps

module ipic_prio_enc (
    input  ipic_pkg::irq_vec_t vec_i,
    output ipic_pkg::prio_t    res_o              // Lowest set bit
);
    logic [7:0] s1_vd;                            // Pairs
    logic [7:0] s1_idx;
    logic [3:0] s2_vd;                            // Quads
    logic [1:0] s2_idx [4];
    logic [1:0] s3_vd;                            // Octets
    logic [2:0] s3_idx [2];

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            s1_vd[i]  = vec_i[2*i] | vec_i[2*i+1];
            s1_idx[i] = ~vec_i[2*i];              // Even bit wins
        end
        for (int i = 0; i < 4; i++) begin
            s2_vd[i]  = s1_vd[2*i] | s1_vd[2*i+1];
            s2_idx[i] = s1_vd[2*i] ? {1'b0, s1_idx[2*i]} : {1'b1, s1_idx[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            s3_vd[i]  = s2_vd[2*i] | s2_vd[2*i+1];
            s3_idx[i] = s2_vd[2*i] ? {1'b0, s2_idx[2*i]} : {1'b1, s2_idx[2*i+1]};
        end
        res_o.vd  = s3_vd[0] | s3_vd[1];
        res_o.idx = s3_vd[0] ? {1'b0, s3_idx[0]} : {1'b1, s3_idx[1]};
    end

endmodule

// ==== design/ipic_pending.sv ====
`timescale 1ns/1ps

module ipic_pending (
    input  logic               clk,
    input  logic               rst_n,
    input  ipic_pkg::irq_vec_t lvl_i,             // Active level per line
    input  ipic_pkg::irq_vec_t edge_i,            // Detected edges
    input  ipic_pkg::irq_vec_t imr_i,             // Mode, 1 = edge
    input  ipic_pkg::irq_vec_t clr_req_i,         // From IPR/ICSR writes
    input  ipic_pkg::prio_t    start_i,           // Line being started
    input  logic               start_en_i,        // Interrupt really starts
    output ipic_pkg::irq_vec_t ipr_o
);
    import ipic_pkg::*;

    irq_vec_t ipr_q;
    irq_vec_t ipr_next;
    irq_vec_t clr_all;                            // Register clears plus SOI
    irq_vec_t clr;                                // Clears that take effect

    always_comb begin
        clr_all = clr_req_i;
        if (start_en_i) begin
            clr_all[start_i.idx] = 1'b1;
        end
    end

    // Active level line in level mode cannot be cleared
    assign clr = clr_all & (~lvl_i | imr_i);

    //----------------------------------------
    // Clear, else follow level, else latch edge
    //----------------------------------------
    assign ipr_next = ~clr & ((~imr_i & lvl_i) | (imr_i & (ipr_q | edge_i)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ipr_q <= '0;
        else        ipr_q <= ipr_next;
    end

    assign ipr_o = ipr_q;

endmodule

// ==== design/ipic_cfg_regs.sv ====
`timescale 1ns/1ps

module ipic_cfg_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  ipic_pkg::cfg_cmd_t  cmd_i,            // Decoded IDX/ICSR writes
    output ipic_pkg::irq_vec_t  ier_o,            // Enable
    output ipic_pkg::irq_vec_t  imr_o,            // Mode, 1 = edge
    output ipic_pkg::irq_vec_t  iinv_o,           // Inversion
    output ipic_pkg::irq_vec_t  iinv_next_o,      // Inversion incl. this write
    output ipic_pkg::irq_idx_t  idx_o             // Line selected for ICSR
);
    import ipic_pkg::*;

    irq_idx_t idx_q;
    irq_vec_t ier_q,  ier_next;
    irq_vec_t imr_q,  imr_next;
    irq_vec_t iinv_q, iinv_next;

    //----------------------------------------
    // ICSR write hits the indexed line
    //----------------------------------------
    always_comb begin
        ier_next  = ier_q;
        imr_next  = imr_q;
        iinv_next = iinv_q;
        if (cmd_i.icsr_wr) begin
            ier_next[idx_q]  = cmd_i.wdata[ICSR_IE];
            imr_next[idx_q]  = cmd_i.wdata[ICSR_IM];
            iinv_next[idx_q] = cmd_i.wdata[ICSR_INV];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q  <= '0;
            ier_q  <= '0;
            imr_q  <= '0;
            iinv_q <= '0;
        end else begin
            if (cmd_i.idx_wr) begin
                idx_q <= cmd_i.wdata[IRQ_IDX_W-1:0];   // Upper bits dropped
            end
            ier_q  <= ier_next;
            imr_q  <= imr_next;
            iinv_q <= iinv_next;
        end
    end

    assign ier_o       = ier_q;
    assign imr_o       = imr_q;
    assign iinv_o      = iinv_q;
    assign iinv_next_o = iinv_next;   // Level detect sees new polarity now
    assign idx_o       = idx_q;

endmodule

// ==== design/ipic_irq_frontend.sv ====
`timescale 1ns/1ps

module ipic_irq_frontend #(
    parameter bit SYNC_EN = 1'b1                  // Two-flop synchronizer on the lines
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ipic_pkg::irq_vec_t lines_i,           // Raw lines from the SoC
    input  ipic_pkg::irq_vec_t inv_i,             // Inversion, next value
    output ipic_pkg::irq_vec_t lvl_o,             // Active level per line
    output ipic_pkg::irq_vec_t edge_o             // Edge into active level
);
    import ipic_pkg::*;

    irq_vec_t lines_s;                            // Lines after optional sync
    irq_vec_t lines_d;                            // Lines one cycle earlier

    //----------------------------------------
    // Optional synchronizer
    //----------------------------------------
    if (SYNC_EN) begin : g_sync
        irq_vec_t meta_q;
        irq_vec_t sync_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                meta_q <= '0;
                sync_q <= '0;
            end else begin
                meta_q <= lines_i;   // May go metastable
                sync_q <= meta_q;
            end
        end
        assign lines_s = sync_q;
    end else begin : g_direct
        assign lines_s = lines_i;    // Lines already in clk domain
    end

    // History for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) lines_d <= '0;
        else        lines_d <= lines_s;
    end

    assign lvl_o  = lines_s ^ inv_i;
    assign edge_o = (lines_s ^ lines_d) & lvl_o;   // Only toggles into active

endmodule

// ==== design/ipic_pkg.sv ====
package ipic_pkg;

    //----------------------------------------
    // Widths and vector types
    //----------------------------------------
    localparam int IRQ_NUM   = 16;   // External interrupt lines
    localparam int IRQ_IDX_W = 4;    // Line index width
    localparam int XLEN      = 32;   // Register data width

    typedef logic [IRQ_NUM-1:0]   irq_vec_t;    // One bit per line
    typedef logic [IRQ_IDX_W-1:0] irq_idx_t;    // Line number
    typedef logic [IRQ_IDX_W:0]   vect_num_t;   // Current vector, MSB set when idle
    typedef logic [XLEN-1:0]      xlen_t;       // Register data word
    typedef logic [2:0]           reg_addr_t;   // Register address

    localparam vect_num_t VOID_VECT = vect_num_t'(IRQ_NUM);   // Nothing in service

    //----------------------------------------
    // Register map
    //----------------------------------------
    localparam reg_addr_t ADDR_CISV = 3'd0;   // Current vector, read only
    localparam reg_addr_t ADDR_IPR  = 3'd2;   // Pending, write 1 to clear
    localparam reg_addr_t ADDR_ISVR = 3'd3;   // In service, read only
    localparam reg_addr_t ADDR_EOI  = 3'd4;   // End of interrupt
    localparam reg_addr_t ADDR_SOI  = 3'd5;   // Start of interrupt
    localparam reg_addr_t ADDR_IDX  = 3'd6;   // Line select for ICSR
    localparam reg_addr_t ADDR_ICSR = 3'd7;   // Per-line control/status

    // ICSR field positions
    localparam int ICSR_IP     = 0;
    localparam int ICSR_IE     = 1;
    localparam int ICSR_IM     = 2;    // 1 = edge, 0 = level
    localparam int ICSR_INV    = 3;
    localparam int ICSR_IS     = 4;
    localparam int ICSR_LN_LSB = 12;   // Line number field

    //----------------------------------------
    // Bundles
    //----------------------------------------
    typedef struct packed {
        logic      rd;      // Read strobe
        logic      wr;      // Write strobe
        reg_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic  idx_wr;      // Write to IDX
        logic  icsr_wr;     // Write to ICSR
        xlen_t wdata;
    } cfg_cmd_t;

    typedef struct packed {
        logic     vd;       // Some bit found
        irq_idx_t idx;      // Lowest set bit
    } prio_t;

endpackage
